//--- design/dds_pkg.sv
package dds_pkg;

  // datapath widths
  localparam int acc_w    = 32;  // phase accumulator
  localparam int phase_w  = 12;  // phase code, acc bits 31..20
  localparam int sample_w = 8;   // unsigned output sample
  localparam int amp_w    = 9;   // amplitude, 256 is unity gain
  localparam int shift_w  = 5;   // resolution shift amount

  // sample mid-point, zero level of the bipolar shapes
  localparam logic [sample_w-1:0] mid_scale = 8'd128;

  // quarter-wave sine table
  localparam int quarter_depth = 64;                      // entries per quadrant
  localparam int quarter_aw    = $clog2(quarter_depth);   // table index width
  localparam     quarter_file  = "sine_quarter.hex";      // hex image, one value per line

  // load edge to first valid sample
  // phase reg + shape reg + scaled output reg
  localparam int pipe_latency = 3;

  // waveform select, matches the 2-bit wave_sel input
  typedef enum logic [1:0] {
    wave_sine     = 2'd0,  // quarter table with quadrant mirroring
    wave_square   = 2'd1,  // msb of phase
    wave_triangle = 2'd2,  // folded ramp
    wave_saw      = 2'd3   // top phase bits straight out
  } wave_sel_e;

endpackage

//--- design/dds_phase_if.sv
`timescale 1ns/1ps

// phase stage to waveform stage, one item per cycle, no handshake
interface dds_phase_if
  import dds_pkg::*;
();

  logic [phase_w-1:0] phase_code;  // accumulator msbs plus offset
  wave_sel_e          wave;        // shape for this item
  logic [amp_w-1:0]   amp;         // gain for this item
  logic               valid;       // qualifies the item this cycle

  modport src (
    output phase_code,
    output wave,
    output amp,
    output valid
  );

  modport dst (
    input phase_code,
    input wave,
    input amp,
    input valid
  );

endinterface

//--- design/dds_phase_accum.sv
`timescale 1ns/1ps

module dds_phase_accum
  import dds_pkg::*;
(
  input  logic               sys_clk,
  input  logic               sys_rst_n,
  input  logic               cfg_load,      // single-cycle config strobe
  input  logic [acc_w-1:0]   freq_word,     // accumulator step
  input  logic [phase_w-1:0] phase_offset,  // added after the shift
  input  logic [shift_w-1:0] res_shift,     // left shift of the accumulator
  input  wave_sel_e          wave_sel,
  input  logic [amp_w-1:0]   amp,
  dds_phase_if.src           ph
);

  logic [acc_w-1:0]   freq_q;    // loaded step
  logic [phase_w-1:0] offset_q;  // loaded offset
  logic [shift_w-1:0] shift_q;   // loaded shift
  wave_sel_e          wave_q;
  logic [amp_w-1:0]   amp_q;
  logic               run_q;     // set by first load, stays set
  logic [acc_w-1:0]   acc_q;     // phase accumulator
  logic [acc_w-1:0]   acc_shifted;
  logic [phase_w-1:0] phase_nxt;

  // scale up the accumulator, then take the top bits as phase
  assign acc_shifted = acc_q << shift_q;
  assign phase_nxt   = acc_shifted[acc_w-1:acc_w-phase_w] + offset_q;  // wraps mod 4096

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      freq_q   <= '0;
      offset_q <= '0;
      shift_q  <= '0;
      wave_q   <= wave_sine;
      amp_q    <= '0;
      run_q    <= 1'b0;
      acc_q    <= '0;
    end
    else if (cfg_load)
    begin
      freq_q   <= freq_word;  // capture config
      offset_q <= phase_offset;
      shift_q  <= res_shift;
      wave_q   <= wave_sel;
      amp_q    <= amp;
      run_q    <= 1'b1;
      acc_q    <= '0;         // sample 0 starts at phase 0
    end
    else
    begin
      acc_q <= acc_q + freq_q;  // n * freq_word after n steps
    end
  end

  // phase register, one edge behind the accumulator
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      ph.phase_code <= '0;
      ph.wave       <= wave_sine;
      ph.amp        <= '0;
      ph.valid      <= 1'b0;
    end
    else
    begin
      ph.phase_code <= phase_nxt;
      ph.wave       <= wave_q;              // travels with its phase
      ph.amp        <= amp_q;
      ph.valid      <= run_q & ~cfg_load;   // load drops the item in flight
    end
  end

endmodule

//--- design/dds_wave_gen.sv
`timescale 1ns/1ps

module dds_wave_gen
  import dds_pkg::*;
(
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                cfg_load,   // flushes items in flight
  dds_phase_if.dst            ph,
  output logic [sample_w-1:0] data_out,
  output logic                out_valid
);

  // quarter-wave magnitudes, q[i] up to 127
  logic [sample_w-1:0] sine_rom [quarter_depth];

  logic [sample_w-1:0]   u;         // top phase bits
  logic [1:0]            quadrant;
  logic [quarter_aw-1:0] idx;       // position inside the quadrant
  logic [quarter_aw-1:0] rom_idx;   // mirrored on odd quadrants
  logic [sample_w-1:0]   q_mag;
  logic [sample_w-1:0]   sine_val;
  logic [sample_w-1:0]   tri_val;
  logic [sample_w-1:0]   square_val;
  logic [sample_w-1:0]   shape_nxt;

  logic [sample_w-1:0] s1_shape;   // stage 1 unscaled sample
  logic [amp_w-1:0]    s1_amp;     // gain aligned with s1_shape

  // valid pipe, [0] is stage 1, msb is the output stage
  logic [pipe_latency-2:0] vld_q;

  logic signed [sample_w:0]         s_diff;   // sample around mid-scale
  logic signed [amp_w:0]            amp_s;    // gain, always positive
  logic signed [sample_w+amp_w+1:0] prod;
  logic signed [sample_w+amp_w+1:0] scaled;   // floor(prod / 256)
  logic [sample_w-1:0]              out_nxt;

  initial
  begin
    $readmemh(quarter_file, sine_rom);
  end

  assign u        = ph.phase_code[phase_w-1:phase_w-sample_w];
  assign quadrant = u[sample_w-1:sample_w-2];
  assign idx      = u[quarter_aw-1:0];
  assign rom_idx  = quadrant[0] ? ~idx : idx;  // ~idx is 63 - idx
  assign q_mag    = sine_rom[rom_idx];

  // upper half above mid-scale, lower half below
  assign sine_val = quadrant[1] ? (mid_scale - q_mag) : (mid_scale + q_mag);

  // 2u rising, 2(255-u) falling
  assign tri_val = u[sample_w-1] ? {~u[sample_w-2:0], 1'b0} : {u[sample_w-2:0], 1'b0};

  assign square_val = ph.phase_code[phase_w-1] ? '0 : '1;  // high first half

  always_comb
  begin
    case (ph.wave)
      wave_sine:     shape_nxt = sine_val;
      wave_square:   shape_nxt = square_val;
      wave_triangle: shape_nxt = tri_val;
      wave_saw:      shape_nxt = u;
      default:       shape_nxt = sine_val;
    endcase
  end

  // stage 1, shape sample and its gain
  always_ff @(posedge sys_clk)
  begin
    s1_shape <= shape_nxt;
    s1_amp   <= ph.amp;
  end

  // signed scaling about 128, amp 256 passes the sample unchanged
  assign s_diff  = $signed({1'b0, s1_shape}) - $signed({1'b0, mid_scale});
  assign amp_s   = $signed({1'b0, s1_amp});
  assign prod    = s_diff * amp_s;
  assign scaled  = prod >>> (amp_w - 1);  // arithmetic, rounds toward -inf
  assign out_nxt = mid_scale + scaled[sample_w-1:0];  // result stays in 0..255

  // stage 2, scaled output held between valid items
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      data_out <= mid_scale;
    end
    else if (vld_q[0])
    begin
      data_out <= out_nxt;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      vld_q <= '0;
    end
    else if (cfg_load)
    begin
      vld_q <= '0;  // drop old config items
    end
    else
    begin
      vld_q <= {vld_q[pipe_latency-3:0], ph.valid};
    end
  end

  assign out_valid = vld_q[pipe_latency-2];

endmodule

//--- design/dds_top.sv
`timescale 1ns/1ps

module dds_top
  import dds_pkg::*;
(
  input  logic                sys_clk,
  input  logic                sys_rst_n,
  input  logic                cfg_load,      // samples all config inputs
  input  logic [acc_w-1:0]    freq_word,
  input  logic [phase_w-1:0]  phase_offset,
  input  logic [shift_w-1:0]  res_shift,
  input  logic [1:0]          wave_sel,      // wave_sel_e encoding
  input  logic [amp_w-1:0]    amp,
  output logic [sample_w-1:0] data_out,
  output logic                out_valid
);

  dds_phase_if ph_if ();  // phase code, shape, gain, valid

  // config capture, accumulator, shift and offset
  dds_phase_accum u_phase (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .cfg_load     (cfg_load),
    .freq_word    (freq_word),
    .phase_offset (phase_offset),
    .res_shift    (res_shift),
    .wave_sel     (wave_sel_e'(wave_sel)),
    .amp          (amp),
    .ph           (ph_if.src)
  );

  // shape lookup and amplitude scaling
  dds_wave_gen u_wave (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .cfg_load  (cfg_load),
    .ph        (ph_if.dst),
    .data_out  (data_out),
    .out_valid (out_valid)
  );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic sys_clk,
  output logic sys_rst_n
);

  initial
  begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;  // 4 ns period
  end

  initial
  begin
    sys_rst_n = 1'b0;
    repeat (3) @(posedge sys_clk);
    @(negedge sys_clk);  // release away from the active edge
    sys_rst_n = 1'b1;
  end

endmodule

//--- verification/dds_chk.sv
`timescale 1ns/1ps

module dds_chk
  import dds_pkg::*;
(
  input logic                sys_clk,
  input logic                sys_rst_n,
  input logic                cfg_load,
  input logic [sample_w-1:0] data_out,
  input logic                out_valid
);

  // value after a reset edge is still quiet
  a_reset_quiet: assert property (@(posedge sys_clk) !sys_rst_n |=> !out_valid)
    else $error("out_valid high while in reset");

  // every stage flushed, so a gap of pipe_latency cycles
  for (genvar k = 1; k <= pipe_latency; k++)
  begin : g_load_gap
    a_load_gap: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
      $past(cfg_load, k) |-> !out_valid)
      else $error("out_valid high %0d cycles after cfg_load", k);
  end

  // output only turns on as the first sample after a load
  a_rise_after_load: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    $rose(out_valid) |-> $past(cfg_load, pipe_latency + 1))
    else $error("out_valid rose without a load pipe_latency cycles before");

  a_data_known: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    out_valid |-> !$isunknown(data_out))
    else $error("data_out unknown while out_valid is high");

endmodule

//--- verification/dds_tb.sv
`timescale 1ns/1ps

module dds_tb
  import dds_pkg::*;
();

  localparam int clk_period = 4;
  localparam int period_n   = 64;  // one turn at freq 2^26
  localparam int first_n    = 16;
  localparam int amp_n      = 32;  // one turn at freq 2^27
  localparam int rnd_n      = 50;
  localparam int rnd_cfgs   = 4;
  localparam int reload_n   = 20;
  localparam int n_loads    = 22;
  localparam int total_n    = first_n + 7 * period_n + 8 * amp_n + rnd_cfgs * rnd_n
                              + 2 * reload_n;
  localparam int watchdog_cycles = total_n + n_loads * (pipe_latency + 2) + 100;

  logic                sys_clk;
  logic                sys_rst_n;
  logic                cfg_load;
  logic [acc_w-1:0]    freq_word;
  logic [phase_w-1:0]  phase_offset;
  logic [shift_w-1:0]  res_shift;
  logic [1:0]          wave_sel;
  logic [amp_w-1:0]    amp;
  logic [sample_w-1:0] data_out;
  logic                out_valid;

  integer              seed;
  logic [sample_w-1:0] q_ref [quarter_depth];  // model copy of the table
  int                  got_smp [$];            // samples of the last run
  wave_sel_e           cur_wave;               // config seen by the model
  logic [acc_w-1:0]    cur_freq;
  logic [phase_w-1:0]  cur_offset;
  logic [shift_w-1:0]  cur_shift;
  logic [amp_w-1:0]    cur_amp;

  tb_clk_gen clk0 (.sys_clk(sys_clk), .sys_rst_n(sys_rst_n));

  dds_top dut0 (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .cfg_load     (cfg_load),
    .freq_word    (freq_word),
    .phase_offset (phase_offset),
    .res_shift    (res_shift),
    .wave_sel     (wave_sel),
    .amp          (amp),
    .data_out     (data_out),
    .out_valid    (out_valid)
  );

  bind dds_top dds_chk chk0 (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .cfg_load  (cfg_load),
    .data_out  (data_out),
    .out_valid (out_valid)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at time %0d ns: %s, got %0d expected %0d",
                          $time, msg, got, exp));
  endtask

  task automatic tick();
    @(posedge sys_clk);
    #1;  // drive and sample clear of the edge
  endtask

  // phase code of sample n from the accumulator value n * freq
  function automatic int phase_ref(input int n);
    logic [acc_w-1:0] acc;
    acc = cur_freq * n;
    acc = acc << cur_shift;
    return (int'(acc >> 20) + int'(cur_offset)) % 4096;
  endfunction

  function automatic int shape_ref(input int p);
    int u;
    int i;
    u = p >> 4;  // top 8 phase bits
    i = u % quarter_depth;
    case (cur_wave)
      wave_square:   return (p < 2048) ? 255 : 0;
      wave_triangle: return (u < 128) ? 2 * u : 2 * (255 - u);
      wave_saw:      return u;
      default:
      begin
        case (u / quarter_depth)  // quadrant
          0:       return 128 + int'(q_ref[i[5:0]]);
          1:       return 128 + int'(q_ref[6'(63 - i)]);
          2:       return 128 - int'(q_ref[i[5:0]]);
          default: return 128 - int'(q_ref[6'(63 - i)]);
        endcase
      end
    endcase
  endfunction

  function automatic int ref_sample(input int n);
    int d;
    d = (shape_ref(phase_ref(n)) - 128) * int'(cur_amp);
    if (d < 0)
      d = -((-d + 255) / 256);  // floor toward -inf
    else
      d = d / 256;
    return 128 + d;
  endfunction

  task automatic load_cfg(input wave_sel_e w, input logic [31:0] f, input logic [11:0] off,
                          input logic [4:0] sh, input logic [8:0] a);
    logic [31:0] junk;
    cur_wave     = w;
    cur_freq     = f;
    cur_offset   = off;
    cur_shift    = sh;
    cur_amp      = a;
    wave_sel     = w;
    freq_word    = f;
    phase_offset = off;
    res_shift    = sh;
    amp          = a;
    cfg_load     = 1'b1;
    tick();
    cfg_load     = 1'b0;
    junk         = $random(seed);  // inputs are don't care without the strobe
    freq_word    = junk;
    phase_offset = junk[11:0];
    res_shift    = junk[16:12];
    wave_sel     = junk[18:17];
    amp          = junk[27:19];
  endtask

  // starts right after the load edge and returns on the first valid sample
  task automatic wait_valid();
    int lat;
    lat = 0;
    while (out_valid !== 1'b1)
    begin
      if (lat > pipe_latency + 4)
        abort_run("out_valid did not come back after cfg_load");
      else
      begin
        tick();
        lat++;
      end
    end
    check_val(lat, pipe_latency, "cycles from cfg_load to first out_valid");
  endtask

  task automatic run_samples(input int cnt);
    got_smp.delete();
    for (int n = 0; n < cnt; n++)
    begin
      check_val(32'(out_valid), 1, $sformatf("out_valid at sample %0d", n));
      check_val(32'(data_out), ref_sample(n), $sformatf("data_out at sample %0d", n));
      got_smp.push_back(int'(data_out));
      tick();
    end
  endtask

  task automatic reset_and_first_load();
    tick();
    while (sys_rst_n !== 1'b1)
    begin
      check_val(32'(out_valid), 0, "out_valid during reset");
      check_val(32'(data_out), 128, "data_out during reset");
      tick();
    end
    repeat (4)
    begin
      check_val(32'(out_valid), 0, "out_valid before the first load");
      tick();
    end
    load_cfg(wave_sine, 32'h0400_0000, '0, '0, 9'd256);
    wait_valid();
    run_samples(first_n);  // high on every cycle
  endtask

  task automatic sine_full_period();
    load_cfg(wave_sine, 32'h0400_0000, '0, '0, 9'd256);
    wait_valid();
    run_samples(period_n);
  endtask

  task automatic shapes_with_offset();
    wave_sel_e shapes [3];
    int        base [$];
    shapes = '{wave_square, wave_triangle, wave_saw};
    foreach (shapes[k])
    begin
      load_cfg(shapes[k], 32'h0400_0000, '0, '0, 9'd256);
      wait_valid();
      run_samples(period_n);
      base = got_smp;
      load_cfg(shapes[k], 32'h0400_0000, 12'd1024, '0, 9'd256);
      wait_valid();
      run_samples(period_n);
      for (int n = 0; n < period_n; n++)  // quarter turn is 16 samples ahead
        check_val(got_smp[n], base[(n + 16) % period_n], "offset 1024 against offset 0");
    end
  endtask

  task automatic amplitude_scaling();
    logic [31:0]      r;
    logic [amp_w-1:0] amps [4];
    r    = $random(seed);
    amps = '{9'd0, 9'd128, {1'b0, r[7:0]}, {1'b0, r[15:8]}};
    for (int w = 0; w < 2; w++)
    begin
      foreach (amps[k])
      begin
        load_cfg(w == 0 ? wave_sine : wave_square, 32'h0800_0000, '0, '0, amps[k]);
        wait_valid();
        run_samples(amp_n);
        if (amps[k] == '0)
          foreach (got_smp[n])
            check_val(got_smp[n], 128, "amp 0 holds mid-scale");
      end
    end
  endtask

  task automatic random_freq_shift();
    logic [31:0] r;
    logic [31:0] f;
    for (int k = 0; k < rnd_cfgs; k++)
    begin
      f = $random(seed);
      r = $random(seed);
      load_cfg(wave_sel_e'(r[1:0]), f, r[13:2], r[18:14], r[27] ? 9'd256 : {1'b0, r[26:19]});
      wait_valid();
      run_samples(rnd_n);
    end
  endtask

  task automatic reload_mid_stream();
    load_cfg(wave_saw, 32'h0200_0000, '0, '0, 9'd256);
    wait_valid();
    run_samples(reload_n);  // pipeline full here
    load_cfg(wave_triangle, 32'h0123_4567, 12'd300, 5'd2, 9'd200);
    wait_valid();           // gap must be exactly pipe_latency
    run_samples(reload_n);  // restarts at n = 0
  endtask

  initial
  begin
    #(watchdog_cycles * clk_period);
    abort_run($sformatf("timeout: tests still running after %0d clock cycles",
                        watchdog_cycles));
  end

  initial
  begin
    seed         = 32'h88cc16c0;
    cfg_load     = 1'b0;
    freq_word    = '0;
    phase_offset = '0;
    res_shift    = '0;
    wave_sel     = '0;
    amp          = '0;
    $readmemh(quarter_file, q_ref);
    reset_and_first_load();
    sine_full_period();
    shapes_with_offset();
    amplitude_scaling();
    random_freq_shift();
    reload_mid_stream();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- design/sine_quarter.hex
02
05
08
0B
0E
11
14
17
1A
1D
20
23
26
29
2C
2F
32
35
38
3A
3D
40
43
45
48
4A
4D
4F
52
54
56
59
5B
5D
5F
61
63
65
67
69
6A
6C
6E
6F
71
72
73
75
76
77
78
79
7A
7B
7C
7C
7D
7D
7E
7E
7F
7F
7F
7F

//--- filelist.f
design/dds_pkg.sv
design/dds_phase_if.sv
design/dds_phase_accum.sv
design/dds_wave_gen.sv
design/dds_top.sv
verification/tb_clk_gen.sv
verification/dds_chk.sv
verification/dds_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dds_tb
RTL_TOP   ?= dds_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_DIR   ?= design
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert

BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter design/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# sine table is opened by bare name, so the run starts next to it
run: $(BIN)
	cd $(RUN_DIR) && $(abspath $(BIN)) > $(abspath $(LOG)) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
